// ==== rtl/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter (
    input  logic       clock,
    input  logic       reset,
    input  logic       clear_i,   // request accepted
    input  logic       step_i,    // beat handshake
    input  logic [1:0] limit_i,   // burst len, sampled on clear
    output logic [1:0] count_o,
    output logic       last_o
);

    logic [1:0] count_q;
    logic [1:0] limit_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            count_q <= 2'd0;
            limit_q <= 2'd0;
        end else if (clear_i) begin
            count_q <= 2'd0;
            limit_q <= limit_i;
        end else if (step_i && !last_o) begin
            count_q <= count_q + 2'd1;  // holds at the limit
        end
    end

    assign count_o = count_q;
    assign last_o  = (count_q == limit_q);

endmodule

// ==== rtl/dcache_axi_macros.svh ====
`ifndef DCA_AXI_MACROS_SVH
`define DCA_AXI_MACROS_SVH

// one AXI data beat, matches the 64-bit bus
`define DCA_BEAT_WIDTH 64

// beats that make up one cache line
`define DCA_LINE_BEATS 4

// whole line as seen by the cache arrays
`define DCA_LINE_WIDTH (`DCA_BEAT_WIDTH * `DCA_LINE_BEATS)

// physical address width on both AXI address channels
`define DCA_ADDR_WIDTH 64

// byte strobe bits per beat
`define DCA_STRB_WIDTH (`DCA_BEAT_WIDTH / 8)

// AXI response encodings, only OKAY is treated as success
`define DCA_RESP_OKAY   2'b00
`define DCA_RESP_EXOKAY 2'b01
`define DCA_RESP_SLVERR 2'b10
`define DCA_RESP_DECERR 2'b11

`endif

// ==== rtl/dcache_axi_pkg.sv ====
`include "dcache_axi_macros.svh"

package dcache_axi_pkg;

    // write-back request from the cache
    typedef struct packed {
        logic [`DCA_ADDR_WIDTH-1:0] addr;
        logic [`DCA_LINE_WIDTH-1:0] line;
        logic [`DCA_STRB_WIDTH-1:0] strb;  // same strobe on every beat
        logic [1:0]                 len;   // beats minus one
        logic [2:0]                 size;
    } wr_req_t;

    // refill request
    typedef struct packed {
        logic [`DCA_ADDR_WIDTH-1:0] addr;
        logic [1:0]                 len;
        logic [2:0]                 size;
    } rd_req_t;

    typedef struct packed {
        logic err;  // bresp was not OKAY
    } wr_resp_t;

    typedef struct packed {
        logic [`DCA_LINE_WIDTH-1:0] line;
        logic                       err;  // bad resp or wrong burst length
    } rd_resp_t;

    // AW and AR carry the same per-transaction fields
    typedef struct packed {
        logic [`DCA_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
    } axi_ax_t;

    typedef struct packed {
        logic [`DCA_BEAT_WIDTH-1:0] data;
        logic [`DCA_STRB_WIDTH-1:0] strb;
        logic                       last;
    } axi_w_t;

    typedef struct packed {
        logic [`DCA_BEAT_WIDTH-1:0] data;
        logic [1:0]                 resp;
        logic                       last;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

endpackage

// ==== rtl/dcache_axi_top.sv ====
`timescale 1ns/1ps

module dcache_axi_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     wr_valid_i,
    input  dcache_axi_pkg::wr_req_t  wr_req_i,
    output logic                     wr_ready_o,
    output logic                     wr_done_o,
    output dcache_axi_pkg::wr_resp_t wr_resp_o,
    input  logic                     rd_valid_i,
    input  dcache_axi_pkg::rd_req_t  rd_req_i,
    output logic                     rd_ready_o,
    output logic                     rd_done_o,
    output dcache_axi_pkg::rd_resp_t rd_resp_o,
    output dcache_axi_pkg::axi_ax_t  aw_o,
    output logic                     aw_valid_o,
    input  logic                     aw_ready_i,
    output dcache_axi_pkg::axi_w_t   w_o,
    output logic                     w_valid_o,
    input  logic                     w_ready_i,
    input  dcache_axi_pkg::axi_b_t   b_i,
    input  logic                     b_valid_i,
    output logic                     b_ready_o,
    output dcache_axi_pkg::axi_ax_t  ar_o,
    output logic                     ar_valid_o,
    input  logic                     ar_ready_i,
    input  dcache_axi_pkg::axi_r_t   r_i,
    input  logic                     r_valid_i,
    output logic                     r_ready_o
);

    logic       wr_accept, wr_step, wr_last, w_last;
    logic [1:0] wr_beat;
    logic       rd_accept, rd_step, rd_end, rd_last;
    logic [1:0] rd_beat;

    // write side
    wr_channel_fsm u_wr_fsm (
        .clock(clock), .reset(reset),
        .wr_valid_i(wr_valid_i), .wr_req_i(wr_req_i), .wr_ready_o(wr_ready_o),
        .aw_ready_i(aw_ready_i), .aw_o(aw_o), .aw_valid_o(aw_valid_o),
        .w_ready_i(w_ready_i), .w_valid_o(w_valid_o), .w_last_o(w_last),
        .b_valid_i(b_valid_i), .b_i(b_i), .b_ready_o(b_ready_o),
        .beat_last_i(wr_last), .accept_o(wr_accept), .step_o(wr_step),
        .wr_done_o(wr_done_o), .wr_resp_o(wr_resp_o)
    );

    beat_counter wr_beats (
        .clock(clock), .reset(reset),
        .clear_i(wr_accept), .step_i(wr_step), .limit_i(wr_req_i.len),
        .count_o(wr_beat), .last_o(wr_last)
    );

    line_unpacker u_unpacker (
        .clock(clock), .reset(reset),
        .load_i(wr_accept), .wr_req_i(wr_req_i),
        .beat_i(wr_beat), .last_i(w_last), .w_o(w_o)
    );

    // read side, runs independently of the write side
    rd_channel_fsm u_rd_fsm (
        .clock(clock), .reset(reset),
        .rd_valid_i(rd_valid_i), .rd_req_i(rd_req_i), .rd_ready_o(rd_ready_o),
        .ar_ready_i(ar_ready_i), .ar_o(ar_o), .ar_valid_o(ar_valid_o),
        .r_valid_i(r_valid_i), .r_last_i(r_i.last), .r_ready_o(r_ready_o),
        .accept_o(rd_accept), .step_o(rd_step), .end_o(rd_end),
        .rd_done_o(rd_done_o)
    );

    beat_counter rd_beats (
        .clock(clock), .reset(reset),
        .clear_i(rd_accept), .step_i(rd_step), .limit_i(rd_req_i.len),
        .count_o(rd_beat), .last_o(rd_last)
    );

    line_assembler u_assembler (
        .clock(clock), .reset(reset),
        .clear_i(rd_accept), .step_i(rd_step), .end_i(rd_end),
        .beat_i(rd_beat), .beat_last_i(rd_last),
        .r_i(r_i), .rd_resp_o(rd_resp_o)
    );

endmodule

// ==== rtl/line_assembler.sv ====
`timescale 1ns/1ps
`include "dcache_axi_macros.svh"

module line_assembler (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     clear_i,      // new refill accepted
    input  logic                     step_i,       // R handshake
    input  logic                     end_i,        // R handshake with r_last
    input  logic [1:0]               beat_i,
    input  logic                     beat_last_i,  // index has reached len
    input  dcache_axi_pkg::axi_r_t   r_i,
    output dcache_axi_pkg::rd_resp_t rd_resp_o
);

    logic [`DCA_LINE_WIDTH-1:0] line_q;
    logic err_q;
    logic beat_err;

    // bad resp, or r_last not lined up with the expected final beat
    assign beat_err = step_i &&
                      ((r_i.resp != `DCA_RESP_OKAY) || (end_i != beat_last_i));

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            line_q <= '0;
            err_q  <= 1'b0;
        end else if (clear_i) begin
            line_q <= '0;  // unreceived beats stay zero
            err_q  <= 1'b0;
        end else begin
            if (step_i) begin
                line_q[beat_i*`DCA_BEAT_WIDTH +: `DCA_BEAT_WIDTH] <= r_i.data;
            end
            if (beat_err) err_q <= 1'b1;  // sticky until next refill
        end
    end

    assign rd_resp_o.line = line_q;
    assign rd_resp_o.err  = err_q;

endmodule

// ==== rtl/line_unpacker.sv ====
`timescale 1ns/1ps
`include "dcache_axi_macros.svh"

module line_unpacker (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    load_i,
    input  dcache_axi_pkg::wr_req_t wr_req_i,
    input  logic [1:0]              beat_i,
    input  logic                    last_i,
    output dcache_axi_pkg::axi_w_t  w_o
);

    logic [`DCA_LINE_WIDTH-1:0] line_q;
    logic [`DCA_STRB_WIDTH-1:0] strb_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            line_q <= '0;
            strb_q <= '0;
        end else if (load_i) begin
            line_q <= wr_req_i.line;
            strb_q <= wr_req_i.strb;
        end
    end

    // beat i is line bits 64i up to 64i+63
    always_comb begin
        w_o.data = line_q[beat_i*`DCA_BEAT_WIDTH +: `DCA_BEAT_WIDTH];
        w_o.strb = strb_q;
        w_o.last = last_i;
    end

endmodule

// ==== rtl/rd_channel_fsm.sv ====
`timescale 1ns/1ps

module rd_channel_fsm (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    rd_valid_i,
    input  dcache_axi_pkg::rd_req_t rd_req_i,
    output logic                    rd_ready_o,
    input  logic                    ar_ready_i,
    output dcache_axi_pkg::axi_ax_t ar_o,
    output logic                    ar_valid_o,
    input  logic                    r_valid_i,
    input  logic                    r_last_i,
    output logic                    r_ready_o,
    output logic                    accept_o,
    output logic                    step_o,
    output logic                    end_o,
    output logic                    rd_done_o
);

    typedef enum logic [1:0] {
        RD_IDLE = 2'b00,
        RD_ADDR = 2'b01,
        RD_DATA = 2'b11
    } rd_state_e;

    rd_state_e state_q, state_d;
    dcache_axi_pkg::axi_ax_t ar_q;
    logic done_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: if (rd_valid_i) state_d = RD_ADDR;
            RD_ADDR: if (ar_ready_i) state_d = RD_DATA;
            RD_DATA: if (end_o) state_d = RD_IDLE;  // needs r_valid too
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= RD_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= end_o;
        end
    end

    always_ff @(posedge clock) begin
        if (accept_o) begin
            ar_q.addr <= rd_req_i.addr;
            ar_q.len  <= {6'd0, rd_req_i.len};
            ar_q.size <= rd_req_i.size;
        end
    end

    assign rd_ready_o = (state_q == RD_IDLE);
    assign accept_o   = rd_ready_o && rd_valid_i;
    assign ar_valid_o = (state_q == RD_ADDR);
    assign ar_o       = ar_q;
    assign r_ready_o  = (state_q == RD_DATA);
    assign step_o     = r_ready_o && r_valid_i;
    assign end_o      = step_o && r_last_i;
    assign rd_done_o  = done_q;

endmodule

// ==== rtl/wr_channel_fsm.sv ====
`timescale 1ns/1ps
`include "dcache_axi_macros.svh"

module wr_channel_fsm (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    wr_valid_i,
    input  dcache_axi_pkg::wr_req_t wr_req_i,
    output logic                    wr_ready_o,
    input  logic                    aw_ready_i,
    output dcache_axi_pkg::axi_ax_t aw_o,
    output logic                    aw_valid_o,
    input  logic                    w_ready_i,
    output logic                    w_valid_o,
    output logic                    w_last_o,
    input  logic                    b_valid_i,
    input  dcache_axi_pkg::axi_b_t  b_i,
    output logic                    b_ready_o,
    input  logic                    beat_last_i,
    output logic                    accept_o,
    output logic                    step_o,
    output logic                    wr_done_o,
    output dcache_axi_pkg::wr_resp_t wr_resp_o
);

    typedef enum logic [1:0] {
        WR_IDLE = 2'b00,
        WR_ADDR = 2'b01,
        WR_DATA = 2'b11,
        WR_RESP = 2'b10
    } wr_state_e;

    wr_state_e state_q, state_d;
    dcache_axi_pkg::axi_ax_t aw_q;
    logic done_q;
    logic err_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: if (wr_valid_i) state_d = WR_ADDR;
            WR_ADDR: if (aw_ready_i) state_d = WR_DATA;
            WR_DATA: if (w_ready_i && beat_last_i) state_d = WR_RESP;
            WR_RESP: if (b_valid_i) state_d = WR_IDLE;
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= WR_IDLE;
            done_q  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= b_ready_o && b_valid_i;  // one cycle after B
            if (b_ready_o && b_valid_i) begin
                err_q <= (b_i.resp != `DCA_RESP_OKAY);
            end
        end
    end

    // AW payload, stable from accept until the next request
    always_ff @(posedge clock) begin
        if (accept_o) begin
            aw_q.addr <= wr_req_i.addr;
            aw_q.len  <= {6'd0, wr_req_i.len};
            aw_q.size <= wr_req_i.size;
        end
    end

    assign wr_ready_o = (state_q == WR_IDLE);
    assign accept_o   = wr_ready_o && wr_valid_i;
    assign aw_valid_o = (state_q == WR_ADDR);
    assign aw_o       = aw_q;
    assign w_valid_o  = (state_q == WR_DATA);
    assign w_last_o   = w_valid_o && beat_last_i;
    assign step_o     = w_valid_o && w_ready_i;  // counter ignores it on last
    assign b_ready_o  = (state_q == WR_RESP);
    assign wr_done_o  = done_q;
    assign wr_resp_o.err = err_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run; the result is taken from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module tb_dcache_axi -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// ==== sim/dcache_axi_assert.sv ====
`timescale 1ns/1ps

module dcache_axi_assert (
    input logic                    clock,
    input logic                    reset,
    input logic                    aw_valid_o,
    input logic                    aw_ready_i,
    input dcache_axi_pkg::axi_ax_t aw_o,
    input logic                    ar_valid_o,
    input logic                    ar_ready_i,
    input dcache_axi_pkg::axi_ax_t ar_o,
    input logic                    w_valid_o,
    input logic                    w_ready_i,
    input logic                    w_last_i,
    input logic                    b_ready_o,
    input logic                    wr_ready_o,
    input logic                    rd_ready_o,
    input logic                    wr_done_o,
    input logic                    rd_done_o
);

    // address channels hold until accepted
    aw_hold: assert property (@(posedge clock) disable iff (!reset)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
        else $error("AW dropped or changed before aw_ready");
    ar_hold: assert property (@(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
        else $error("AR dropped or changed before ar_ready");

    // accepted last beat closes the W phase and opens B
    w_last_end: assert property (@(posedge clock) disable iff (!reset)
        w_valid_o && w_ready_i && w_last_i |=> !w_valid_o && b_ready_o)
        else $error("W last did not end the data phase");

    wr_done_pulse: assert property (@(posedge clock) disable iff (!reset)
        wr_done_o |=> !wr_done_o)
        else $error("wr_done_o longer than one cycle");
    rd_done_pulse: assert property (@(posedge clock) disable iff (!reset)
        rd_done_o |=> !rd_done_o)
        else $error("rd_done_o longer than one cycle");

    // ready comes back only together with the done strobe
    wr_busy: assert property (@(posedge clock) disable iff (!reset)
        $rose(wr_ready_o) |-> wr_done_o)
        else $error("wr_ready_o returned before the write completed");
    rd_busy: assert property (@(posedge clock) disable iff (!reset)
        $rose(rd_ready_o) |-> rd_done_o)
        else $error("rd_ready_o returned before the refill completed");

endmodule

bind dcache_axi_top dcache_axi_assert u_assert (
    .clock(clock), .reset(reset),
    .aw_valid_o(aw_valid_o), .aw_ready_i(aw_ready_i), .aw_o(aw_o),
    .ar_valid_o(ar_valid_o), .ar_ready_i(ar_ready_i), .ar_o(ar_o),
    .w_valid_o(w_valid_o), .w_ready_i(w_ready_i), .w_last_i(w_o.last),
    .b_ready_o(b_ready_o),
    .wr_ready_o(wr_ready_o), .rd_ready_o(rd_ready_o),
    .wr_done_o(wr_done_o), .rd_done_o(rd_done_o)
);

// ==== sim/tb_dcache_axi.sv ====
`timescale 1ns/1ps
`include "dcache_axi_macros.svh"

module tb_dcache_axi;

    localparam int MAX_STALL = 4;
    localparam int NUM_XFERS = 8;  // write and read bursts over all tests
    localparam int TIMEOUT_CYCLES = NUM_XFERS * 4 * MAX_STALL * 16 + 200;

    logic clock, reset;
    logic wr_valid_i, wr_ready_o, wr_done_o;
    logic rd_valid_i, rd_ready_o, rd_done_o;
    dcache_axi_pkg::wr_req_t  wr_req_i;
    dcache_axi_pkg::wr_resp_t wr_resp_o;
    dcache_axi_pkg::rd_req_t  rd_req_i;
    dcache_axi_pkg::rd_resp_t rd_resp_o;
    dcache_axi_pkg::axi_ax_t  aw_o, ar_o;
    dcache_axi_pkg::axi_w_t   w_o;
    dcache_axi_pkg::axi_b_t   b_i;
    dcache_axi_pkg::axi_r_t   r_i;
    logic aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, b_valid_i, b_ready_o;
    logic ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;

    logic [63:0] mem [0:255];  // slave memory with one word per 8-byte address
    dcache_axi_pkg::wr_req_t cur_wr;
    dcache_axi_pkg::rd_req_t cur_rd;
    int errors = 0;
    int checks = 0;

    dcache_axi_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("timeout: a transaction never completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_ax(input string name, input dcache_axi_pkg::axi_ax_t got,
                            input dcache_axi_pkg::axi_ax_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_w(input dcache_axi_pkg::axi_w_t got, input dcache_axi_pkg::axi_w_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL w_o got %h expected %h", got, exp);
        end
    endtask

    task automatic check_wr_resp(input dcache_axi_pkg::wr_resp_t got,
                                 input dcache_axi_pkg::wr_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL wr_resp_o got %h expected %h", got, exp);
        end
    endtask

    task automatic check_rd_resp(input dcache_axi_pkg::rd_resp_t got,
                                 input dcache_axi_pkg::rd_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL rd_resp_o got %h expected %h", got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("%s: saw %0d beats where %0d were due", what, got, exp);
        end
    endtask

    function automatic logic [255:0] random_line();
        logic [255:0] v;
        for (int k = 0; k < 8; k++) v[32*k +: 32] = $urandom;
        return v;
    endfunction

    function automatic logic [63:0] word_addr(input int idx);
        return {32'h8000_0000, 21'd0, 8'(idx), 3'b000};
    endfunction

    // line as the slave returns it with zeros past n_beats
    function automatic logic [255:0] expected_line(input int base, input int n_beats);
        logic [255:0] v;
        v = '0;
        for (int i = 0; i < n_beats; i++) v[64*i +: 64] = mem[(base + i) % 256];
        return v;
    endfunction

    // AXI write slave taking AW and stalled W beats, then B with the given resp
    task automatic serve_write_burst(input logic [1:0] bresp, output int beats);
        dcache_axi_pkg::axi_ax_t exp_ax;
        dcache_axi_pkg::axi_w_t exp_w;
        logic seen_last;
        int base;
        exp_ax = '{addr: cur_wr.addr, len: {6'd0, cur_wr.len}, size: cur_wr.size};
        base = int'(cur_wr.addr[10:3]);
        beats = 0;
        seen_last = 1'b0;
        repeat ($urandom % MAX_STALL) @(negedge clock);
        @(negedge clock);
        aw_ready_i = 1'b1;
        while (!aw_valid_o) @(negedge clock);
        check_ax("aw_o", aw_o, exp_ax);
        while (!seen_last && beats < 4) begin
            repeat ($urandom % MAX_STALL) begin
                @(negedge clock);
                aw_ready_i = 1'b0;
                w_ready_i  = 1'b0;
            end
            @(negedge clock);
            aw_ready_i = 1'b0;
            w_ready_i  = 1'b1;
            while (!w_valid_o) @(negedge clock);
            exp_w.data = cur_wr.line[64*beats +: 64];
            exp_w.strb = cur_wr.strb;
            exp_w.last = (beats == int'(cur_wr.len));
            check_w(w_o, exp_w);
            for (int k = 0; k < 8; k++) begin
                if (w_o.strb[k]) mem[(base + beats) % 256][8*k +: 8] = w_o.data[8*k +: 8];
            end
            seen_last = w_o.last;
            beats++;
        end
        @(negedge clock);
        w_ready_i = 1'b0;
        repeat ($urandom % MAX_STALL) @(negedge clock);
        b_valid_i = 1'b1;
        b_i.resp  = bresp;
        while (!b_ready_o) @(negedge clock);
        @(negedge clock);
        b_valid_i = 1'b0;
    endtask

    // AXI read slave sending n_beats beats with SLVERR on bad_beat and last on the final one
    task automatic return_read_burst(input int n_beats, input int bad_beat);
        dcache_axi_pkg::axi_ax_t exp_ax;
        int base;
        exp_ax = '{addr: cur_rd.addr, len: {6'd0, cur_rd.len}, size: cur_rd.size};
        base = int'(cur_rd.addr[10:3]);
        repeat ($urandom % MAX_STALL) @(negedge clock);
        @(negedge clock);
        ar_ready_i = 1'b1;
        while (!ar_valid_o) @(negedge clock);
        check_ax("ar_o", ar_o, exp_ax);
        for (int i = 0; i < n_beats; i++) begin
            repeat ($urandom % MAX_STALL) begin
                @(negedge clock);
                ar_ready_i = 1'b0;
                r_valid_i  = 1'b0;
            end
            @(negedge clock);
            ar_ready_i = 1'b0;
            r_valid_i  = 1'b1;
            r_i.data   = mem[(base + i) % 256];
            r_i.resp   = (i == bad_beat) ? `DCA_RESP_SLVERR : `DCA_RESP_OKAY;
            r_i.last   = (i == n_beats - 1);
            while (!r_ready_o) @(negedge clock);  // held until accepted
        end
        @(negedge clock);
        r_valid_i = 1'b0;
        r_i.last  = 1'b0;
    endtask

    task automatic request_write_back(input dcache_axi_pkg::wr_req_t req,
                                      output dcache_axi_pkg::wr_resp_t got);
        @(negedge clock);
        wr_valid_i = 1'b1;
        wr_req_i   = req;
        while (!wr_ready_o) @(negedge clock);
        @(negedge clock);
        wr_valid_i = 1'b0;
        while (!wr_done_o) @(negedge clock);
        got = wr_resp_o;
    endtask

    task automatic issue_refill(input dcache_axi_pkg::rd_req_t req,
                                output dcache_axi_pkg::rd_resp_t got);
        @(negedge clock);
        rd_valid_i = 1'b1;
        rd_req_i   = req;
        while (!rd_ready_o) @(negedge clock);
        @(negedge clock);
        rd_valid_i = 1'b0;
        while (!rd_done_o) @(negedge clock);
        got = rd_resp_o;
    endtask

    task automatic reset_state_test();
        @(negedge clock);
        check_bit("wr_ready_o", wr_ready_o, 1'b1);
        check_bit("rd_ready_o", rd_ready_o, 1'b1);
        check_bit("aw_valid_o", aw_valid_o, 1'b0);
        check_bit("w_valid_o", w_valid_o, 1'b0);
        check_bit("ar_valid_o", ar_valid_o, 1'b0);
        check_bit("b_ready_o", b_ready_o, 1'b0);
        check_bit("r_ready_o", r_ready_o, 1'b0);
        check_bit("wr_done_o", wr_done_o, 1'b0);
        check_bit("rd_done_o", rd_done_o, 1'b0);
    endtask

    task automatic write_back_test(input logic [1:0] len, input logic [7:0] strb,
                                   input logic [1:0] bresp, input int idx);
        dcache_axi_pkg::wr_resp_t got;
        dcache_axi_pkg::wr_resp_t exp;
        int beats;
        cur_wr = '{addr: word_addr(idx), line: random_line(), strb: strb, len: len,
                   size: 3'd3};
        exp.err = (bresp != `DCA_RESP_OKAY);
        fork
            request_write_back(cur_wr, got);
            serve_write_burst(bresp, beats);
        join
        check_count("write burst", beats, int'(len) + 1);
        check_wr_resp(got, exp);
        if (strb == 8'hff) begin
            for (int i = 0; i <= int'(len); i++) begin
                checks++;
                if (mem[idx + i] !== cur_wr.line[64*i +: 64]) begin
                    errors++;
                    $display("FAIL mem[%0d] got %h expected %h", idx + i, mem[idx + i],
                             cur_wr.line[64*i +: 64]);
                end
            end
        end
    endtask

    task automatic refill_test(input logic [1:0] len, input int n_beats, input int bad_beat,
                               input int idx);
        dcache_axi_pkg::rd_resp_t got;
        dcache_axi_pkg::rd_resp_t exp;
        cur_rd = '{addr: word_addr(idx), len: len, size: 3'd3};
        fork
            issue_refill(cur_rd, got);
            return_read_burst(n_beats, bad_beat);
        join
        exp.line = expected_line(idx, n_beats);
        exp.err  = (bad_beat >= 0 || n_beats != int'(len) + 1);
        check_rd_resp(got, exp);
    endtask

    // both channels started on the same falling edge
    task automatic overlap_test();
        fork
            write_back_test(2'd3, 8'hff, `DCA_RESP_OKAY, 32);
            refill_test(2'd3, 4, -1, 160);
        join
    endtask

    initial begin
        void'($urandom(32'h9ee));
        for (int i = 0; i < 256; i++) mem[i] = {32'(i) * 32'h9e37_79b9, ~32'(i)};
        reset = 1'b0;
        wr_valid_i = 1'b0;
        wr_req_i = '0;
        rd_valid_i = 1'b0;
        rd_req_i = '0;
        aw_ready_i = 1'b0;
        w_ready_i = 1'b0;
        b_valid_i = 1'b0;
        b_i = '0;
        ar_ready_i = 1'b0;
        r_valid_i = 1'b0;
        r_i = '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;

        reset_state_test();
        write_back_test(2'd3, 8'hff, `DCA_RESP_OKAY, 8);
        write_back_test(2'd1, 8'h0f, `DCA_RESP_SLVERR, 16);
        refill_test(2'd3, 4, -1, 100);
        refill_test(2'd1, 2, -1, 120);
        refill_test(2'd1, 2, 1, 120);  // error resp on the second beat
        refill_test(2'd1, 1, -1, 120); // r_last one beat early
        overlap_test();

        repeat (2) @(negedge clock);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/dcache_axi_pkg.sv
rtl/beat_counter.sv
rtl/wr_channel_fsm.sv
rtl/rd_channel_fsm.sv
rtl/line_unpacker.sv
rtl/line_assembler.sv
rtl/dcache_axi_top.sv
sim/dcache_axi_assert.sv
sim/tb_dcache_axi.sv
